//--- hw/cpuCore_settings.svh
// Core-wide width and size settings for the integer pipeline tail.

`ifndef CPU_CORE_SETTINGS_SVH
`define CPU_CORE_SETTINGS_SVH

// ############################################################
// Architectural widths
// ############################################################

`define DATA_W  32  // Data and instruction width.
`define REG_AW  5   // Register address width.

// ############################################################
// Register file size
// ############################################################

`define REG_NUM 32  // General registers, r0 included.

`endif

//--- hw/cpuCorePkg.sv
// Shared types for the memory-stage-2 to writeback path and the register file.

`include "cpuCore_settings.svh"

package cpuCorePkg;

    // Writeback source, load keeps the top code.
    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,  // Execute result.
        WB_LINK = 2'b01,  // Link address from execute.
        WB_MOVE = 2'b10,  // B operand for MTHI and MTLO.
        WB_LOAD = 2'b11   // Aligned load data.
    } wbSelE;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,   // Signed byte.
        LD_BU   = 3'd2,   // Unsigned byte.
        LD_H    = 3'd3,   // Signed halfword.
        LD_HU   = 3'd4,   // Unsigned halfword.
        LD_W    = 3'd5
    } loadOpE;

    typedef struct packed {
        logic rfWr;       // General register write.
        logic hiWr;
        logic loWr;
    } regsWrType;

    // ############################################################
    // Stage buses
    // ############################################################

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] instr;
        logic [`DATA_W-1:0] result;
        logic [`DATA_W-1:0] outB;
        logic [`DATA_W-1:0] rawMem;     // Unaligned memory word.
        logic [1:0]         memAddrLo;  // Byte offset of the access.
        loadOpE             loadOp;
        wbSelE              wbSel;
        logic [`REG_AW-1:0] dst;
        regsWrType          regsWr;
    } mem2WbBus;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] instr;
        logic [`DATA_W-1:0] result;
        logic [`DATA_W-1:0] outB;
        logic [`DATA_W-1:0] dmOut;      // Extended load value.
        wbSelE              wbSel;
        logic [`REG_AW-1:0] dst;
        regsWrType          regsWr;
    } wbInBus;

endpackage

//--- hw/loadAligner.sv
// Load aligner, extracts and extends the loaded byte, halfword or word.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module loadAligner
    import cpuCorePkg::*;
(
    input  mem2WbBus m2Bus,
    output wbInBus   wbIn
);

    logic [7:0]         byteSel;
    logic [15:0]        halfSel;
    logic [`DATA_W-1:0] loadVal;

    // ############################################################
    // Lane selection
    // ############################################################

    always_comb begin
        case (m2Bus.memAddrLo)
            2'd0:    byteSel = m2Bus.rawMem[7:0];
            2'd1:    byteSel = m2Bus.rawMem[15:8];
            2'd2:    byteSel = m2Bus.rawMem[23:16];
            default: byteSel = m2Bus.rawMem[31:24];
        endcase
    end

    // Bit 0 of the offset is ignored for halfwords.
    assign halfSel = m2Bus.memAddrLo[1] ? m2Bus.rawMem[31:16] : m2Bus.rawMem[15:0];

    // ############################################################
    // Extension by load type
    // ############################################################

    always_comb begin
        case (m2Bus.loadOp)
            LD_B:    loadVal = {{(`DATA_W-8){byteSel[7]}}, byteSel};     // Sign extend.
            LD_BU:   loadVal = {{(`DATA_W-8){1'b0}}, byteSel};           // Zero extend.
            LD_H:    loadVal = {{(`DATA_W-16){halfSel[15]}}, halfSel};
            LD_HU:   loadVal = {{(`DATA_W-16){1'b0}}, halfSel};
            default: loadVal = m2Bus.rawMem;                             // LW and no load.
        endcase
    end

    // Remaining fields pass unchanged.
    always_comb begin
        wbIn.pc     = m2Bus.pc;
        wbIn.instr  = m2Bus.instr;
        wbIn.result = m2Bus.result;
        wbIn.outB   = m2Bus.outB;
        wbIn.dmOut  = loadVal;
        wbIn.wbSel  = m2Bus.wbSel;
        wbIn.dst    = m2Bus.dst;
        wbIn.regsWr = m2Bus.regsWr;
    end

endmodule

//--- hw/wbStage.sv
// Writeback stage, pipeline register with flush and hold, result select and write mask.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module wbStage
    import cpuCorePkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               flush,
    input  logic               wr,
    input  logic               disWr,
    input  wbInBus             wbIn,
    output logic [`DATA_W-1:0] wbResult,
    output logic [`DATA_W-1:0] wbPc,
    output logic [`REG_AW-1:0] wbDst,
    output regsWrType          wbRegsWr,
    output regsWrType          finalWr
);

    wbSelE              wbSelQ;
    logic [`DATA_W-1:0] resultQ;
    logic [`DATA_W-1:0] outBQ;
    logic [`DATA_W-1:0] dmOutQ;

    // ############################################################
    // Stage register
    // ############################################################

    // Flush has priority over the hold enable.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbPc     <= '0;
            wbDst    <= '0;
            wbRegsWr <= '0;
            wbSelQ   <= WB_ALU;
        end else if (flush) begin
            wbPc     <= '0;  // Bubble.
            wbDst    <= '0;
            wbRegsWr <= '0;
            wbSelQ   <= WB_ALU;
        end else if (wr) begin
            wbPc     <= wbIn.pc;
            wbDst    <= wbIn.dst;
            wbRegsWr <= wbIn.regsWr;
            wbSelQ   <= wbIn.wbSel;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            resultQ <= wbIn.result;
            outBQ   <= wbIn.outB;
            dmOutQ  <= wbIn.dmOut;
        end
    end

    // ############################################################
    // Result select and write mask
    // ############################################################

    always_comb begin
        case (wbSelQ)
            WB_LOAD: wbResult = dmOutQ;
            WB_MOVE: wbResult = outBQ;    // Move to HI or LO.
            WB_ALU,
            WB_LINK: wbResult = resultQ;
            default: wbResult = resultQ;
        endcase
    end

    // No register write while the data cache stalls the pipe.
    assign finalWr = disWr ? '0 : wbRegsWr;

endmodule

//--- hw/regFile.sv
// Register file, 32 general registers plus HI and LO with write-through bypass.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module regFile
    import cpuCorePkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic [`REG_AW-1:0] wrAddr,
    input  logic [`DATA_W-1:0] wrData,
    input  regsWrType          wrEn,
    input  logic [`REG_AW-1:0] rdAddrA,
    input  logic [`REG_AW-1:0] rdAddrB,
    output logic [`DATA_W-1:0] rdDataA,
    output logic [`DATA_W-1:0] rdDataB,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);

    logic [`DATA_W-1:0] regs [`REG_NUM];
    logic [`DATA_W-1:0] hiQ;
    logic [`DATA_W-1:0] loQ;

    // Read one general port, pending write wins over stored data.
    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_AW-1:0] addr);
        logic [`DATA_W-1:0] val;
        if (addr == '0) begin
            val = '0;                          // r0 is hardwired.
        end else if (wrEn.rfWr && (wrAddr == addr)) begin
            val = wrData;                      // Bypass.
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // ############################################################
    // Write side
    // ############################################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn.rfWr && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hiQ <= '0;
            loQ <= '0;
        end else begin
            if (wrEn.hiWr) begin
                hiQ <= wrData;
            end
            if (wrEn.loWr) begin
                loQ <= wrData;
            end
        end
    end

    // ############################################################
    // Read side
    // ############################################################

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    assign hi = wrEn.hiWr ? wrData : hiQ;  // HI bypass.
    assign lo = wrEn.loWr ? wrData : loQ;  // LO bypass.

endmodule

//--- hw/wbTop.sv
// Writeback top, load aligner into writeback stage into register file.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module wbTop
    import cpuCorePkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               flush,
    input  logic               wr,
    input  logic               disWr,
    input  mem2WbBus           m2Bus,
    input  logic [`REG_AW-1:0] rdAddrA,
    input  logic [`REG_AW-1:0] rdAddrB,
    output logic [`DATA_W-1:0] wbPc,
    output logic [`DATA_W-1:0] wbResult,
    output logic [`REG_AW-1:0] wbDst,
    output regsWrType          wbRegsWr,
    output regsWrType          finalWr,
    output logic [`DATA_W-1:0] rdDataA,
    output logic [`DATA_W-1:0] rdDataB,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);

    wbInBus wbIn;  // Aligned bus into the stage register.

    loadAligner u_loadAligner (
        .m2Bus    (m2Bus),
        .wbIn     (wbIn)
    );

    wbStage u_wbStage (
        .clk      (clk),
        .arstN    (arstN),
        .flush    (flush),
        .wr       (wr),
        .disWr    (disWr),
        .wbIn     (wbIn),
        .wbResult (wbResult),
        .wbPc     (wbPc),
        .wbDst    (wbDst),
        .wbRegsWr (wbRegsWr),
        .finalWr  (finalWr)
    );

    regFile u_regFile (
        .clk      (clk),
        .arstN    (arstN),
        .wrAddr   (wbDst),
        .wrData   (wbResult),
        .wrEn     (finalWr),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

//--- verification/wbTb_asserts.sv
// Concurrent checks on the writeback top, bound into wbTop.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module wbTbAsserts
    import cpuCorePkg::*;
(
    input logic               clk,
    input logic               arstN,
    input logic               flush,
    input logic               disWr,
    input regsWrType          wbRegsWr,
    input regsWrType          finalWr,
    input logic [`REG_AW-1:0] rdAddrA,
    input logic [`DATA_W-1:0] rdDataA
);

    maskedNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        disWr |-> finalWr == '0)
        else $error("finalWr active while disWr is high");

    zeroRegReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        rdAddrA == '0 |-> rdDataA == '0)
        else $error("register 0 read back a nonzero value");

    // Bubble after flush carries no strobes.
    flushClearsWr: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> wbRegsWr == '0)
        else $error("wbRegsWr nonzero one edge after flush");

endmodule

bind wbTop wbTbAsserts u_wbTbAsserts (.*);

//--- verification/wbTb.sv
// Directed testbench for the writeback top, checked against a register model.

`timescale 1ns/10ps

`include "cpuCore_settings.svh"

module wbTb
    import cpuCorePkg::*;
();

    localparam regsWrType WR_NONE = 3'b000;
    localparam regsWrType WR_RF   = 3'b100;
    localparam regsWrType WR_HI   = 3'b010;
    localparam regsWrType WR_LO   = 3'b001;

    logic               clk, arstN, flush, wr, disWr;
    mem2WbBus           m2Bus;
    logic [`REG_AW-1:0] rdAddrA, rdAddrB, wbDst;
    logic [`DATA_W-1:0] wbPc, wbResult, rdDataA, rdDataB, hi, lo;
    regsWrType          wbRegsWr, finalWr;

    logic [`DATA_W-1:0] regModel [`REG_NUM];  // Expected architectural state.
    logic [`DATA_W-1:0] hiModel, loModel, pcNext;
    integer             seed;
    int                 valueErrors, timeoutErrors;

    wbTop u_wbTop (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // ############################################################
    // Compare and wait helpers
    // ############################################################

    task automatic checkWord(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkWr(input string name, input regsWrType got, input regsWrType exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Step edges until the stage shows the given pc.
    task automatic waitPc(input logic [`DATA_W-1:0] expPc);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (wbPc !== expPc && cycles < 8);
        if (wbPc !== expPc) begin
            timeoutErrors++;
            $display("timeout at %0t: the stage never showed pc %h", $time, expPc);
        end
    endtask

    task automatic checkReg(input logic [`REG_AW-1:0] addr);
        rdAddrA = addr;
        rdAddrB = addr;
        #1;
        checkWord("rdDataA", rdDataA, regModel[addr]);
        checkWord("rdDataB", rdDataB, regModel[addr]);
    endtask

    // ############################################################
    // Items and expected results
    // ############################################################

    function automatic mem2WbBus makeItem(input wbSelE sel, input regsWrType regsWr);
        mem2WbBus item;
        item.pc        = pcNext;
        item.instr     = $random(seed);
        item.result    = $random(seed);
        item.outB      = $random(seed);
        item.rawMem    = $random(seed);
        item.memAddrLo = $random(seed);
        item.loadOp    = LD_NONE;
        item.wbSel     = sel;
        item.dst       = 1 + ($unsigned($random(seed)) % 31);  // Nonzero register.
        item.regsWr    = regsWr;
        pcNext         = pcNext + 4;
        return item;
    endfunction

    function automatic logic [`DATA_W-1:0] expectResult(input mem2WbBus item);
        logic [7:0]  b;
        logic [15:0] h;
        b = item.rawMem >> (8 * item.memAddrLo);      // Addressed byte lane.
        h = item.rawMem >> (16 * item.memAddrLo[1]);  // Addressed halfword.
        if (item.wbSel == WB_MOVE) return item.outB;
        if (item.wbSel != WB_LOAD) return item.result;
        case (item.loadOp)
            LD_B:    return $signed(b);
            LD_BU:   return b;
            LD_H:    return $signed(h);
            LD_HU:   return h;
            default: return item.rawMem;
        endcase
    endfunction

    // Capture one item, check the stage and update the model.
    task automatic issue(input mem2WbBus item);
        logic [`DATA_W-1:0] exp;
        exp   = expectResult(item);
        m2Bus = item;
        wr    = 1'b1;
        waitPc(item.pc);
        checkWord("wbResult", wbResult, exp);
        checkWord("wbDst", wbDst, item.dst);
        checkWr("wbRegsWr", wbRegsWr, item.regsWr);
        checkWr("finalWr", finalWr, disWr ? WR_NONE : item.regsWr);
        if (!disWr && item.regsWr.rfWr && item.dst != 0) regModel[item.dst] = exp;
        if (!disWr && item.regsWr.hiWr) hiModel = exp;
        if (!disWr && item.regsWr.loWr) loModel = exp;
    endtask

    // Flushed item must leave the register file alone.
    task automatic flushStage();
        mem2WbBus item;
        item  = makeItem(WB_ALU, WR_RF);
        m2Bus = item;
        flush = 1'b1;
        wr    = 1'b1;
        waitPc('0);
        checkWr("wbRegsWr", wbRegsWr, WR_NONE);
        flush = 1'b0;
        wr    = 1'b0;
        checkReg(item.dst);
    endtask

    // ############################################################
    // Directed tests
    // ############################################################

    task automatic aluLinkMoveTest();
        for (int i = 0; i < 9; i++) issue(makeItem(wbSelE'(i % 3), WR_RF));
    endtask

    task automatic loadTest();
        mem2WbBus item;
        for (int i = 0; i < 24; i++) begin
            item           = makeItem(WB_LOAD, WR_RF);
            item.loadOp    = loadOpE'(i / 4);  // Every type at every offset.
            item.memAddrLo = i % 4;
            issue(item);
        end
    endtask

    task automatic holdFlushTest();
        mem2WbBus held;
        held = makeItem(WB_ALU, WR_RF);
        issue(held);
        m2Bus = makeItem(WB_LOAD, WR_RF);  // Blocked by the hold.
        wr    = 1'b0;
        waitPc(held.pc);
        checkWord("wbResult", wbResult, held.result);
        checkWord("wbDst", wbDst, held.dst);
        checkWr("finalWr", finalWr, held.regsWr);  // Strobes stay up while held.
        flushStage();
    endtask

    task automatic writeDisableTest();
        mem2WbBus item;
        item  = makeItem(WB_ALU, WR_RF);
        disWr = 1'b1;
        issue(item);
        flushStage();  // Still masked at the flush edge.
        disWr = 1'b0;
        checkReg(item.dst);
    endtask

    task automatic zeroHiLoTest();
        mem2WbBus item;
        item     = makeItem(WB_ALU, WR_RF);
        item.dst = '0;
        issue(item);
        issue(makeItem(WB_MOVE, WR_HI));
        issue(makeItem(WB_MOVE, WR_LO));
        flushStage();
        checkReg('0);
        checkWord("hi", hi, hiModel);
        checkWord("lo", lo, loModel);
    endtask

    task automatic bypassTest();
        mem2WbBus item;
        for (int i = 0; i < 4; i++) begin
            item = makeItem(WB_ALU, WR_RF);
            issue(item);
            checkReg(item.dst);  // Before the storing edge.
        end
    endtask

    initial begin
        seed          = 32'h3e13;
        pcNext        = 32'h100;
        valueErrors   = 0;
        timeoutErrors = 0;
        arstN         = 1'b0;
        flush         = 1'b0;
        wr            = 1'b0;
        disWr         = 1'b0;
        m2Bus         = '0;
        rdAddrA       = '0;
        rdAddrB       = '0;
        hiModel       = '0;
        loModel       = '0;
        for (int i = 0; i < `REG_NUM; i++) regModel[i] = '0;
        repeat (4) @(posedge clk);
        #1 arstN = 1'b1;
        checkWord("wbPc", wbPc, '0);
        checkWord("wbDst", wbDst, '0);
        checkWr("wbRegsWr", wbRegsWr, WR_NONE);
        aluLinkMoveTest();
        loadTest();
        holdFlushTest();
        writeDisableTest();
        zeroHiLoTest();
        bypassTest();
        flushStage();
        for (int i = 0; i < `REG_NUM; i++) begin
            @(posedge clk);
            #1;
            checkReg(i);
        end
        checkWord("hi", hi, hiModel);
        checkWord("lo", lo, loModel);
        $display("%0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/cpuCorePkg.sv
hw/loadAligner.sv
hw/wbStage.sv
hw/regFile.sv
hw/wbTop.sv
verification/wbTb_asserts.sv
verification/wbTb.sv
